// ==== include/systolic_params.svh ====
// array geometry, bus widths and register map shared by the rtl and the testbench
`ifndef SYSTOLIC_PARAMS_SVH
`define SYSTOLIC_PARAMS_SVH

`define SA_DIM     4   // rows and columns of the cell grid
`define SA_ELEM_W  8   // signed operand width
`define SA_ACC_W   32  // signed accumulator width
`define SA_DATA_W  32  // axi4-lite data width
`define SA_ADDR_W  8   // axi4-lite address width

// last product reaches cell (3,3) in compute cycle 9
`define SA_COMPUTE_CYCLES 10

// register map (byte offsets)
`define REG_CTRL   8'h00  // bit 0 starts a run
`define REG_STATUS 8'h04  // bit 0 busy, bit 1 done
`define REG_A_BASE 8'h10  // one word per row of a, byte 3 is column 0
`define REG_B_BASE 8'h20  // one word per row of b
`define REG_C_BASE 8'h40  // sixteen result words, row-major

`endif

// ==== hw/systolic_pkg.sv ====
// element, matrix and axi4-lite channel types used across the systolic multiplier
`default_nettype none
`include "systolic_params.svh"

package systolic_pkg;

    typedef logic signed [`SA_ELEM_W-1:0] elem_t;
    typedef logic signed [`SA_ACC_W-1:0] acc_t;

    // both operand matrices, indexed [row][col]
    typedef struct packed {
        elem_t [`SA_DIM-1:0][`SA_DIM-1:0] a;
        elem_t [`SA_DIM-1:0][`SA_DIM-1:0] b;
    } mm_operands_t;

    typedef struct packed {
        acc_t [`SA_DIM-1:0][`SA_DIM-1:0] c;  // c[row][col]
    } mm_result_t;

    // manager to subordinate
    typedef struct packed {
        logic                  awvalid;
        logic [`SA_ADDR_W-1:0] awaddr;
        logic                  wvalid;
        logic [`SA_DATA_W-1:0] wdata;
        logic                  bready;
        logic                  arvalid;
        logic [`SA_ADDR_W-1:0] araddr;
        logic                  rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [`SA_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hw/skew_feeder.sv ====
// feeds one operand row or column into the array edge, delayed by SKEW zero elements
`default_nettype none
`include "systolic_params.svh"

module skew_feeder #(
    parameter int SKEW = 0  // zeros presented before the first element
) (
    input  wire logic                                  clk,
    input  wire logic                                  reset,
    input  wire logic                                  load_i,
    input  wire systolic_pkg::elem_t [`SA_DIM-1:0]     data_i,  // element 0 leaves first
    input  wire logic                                  shift_i,
    output systolic_pkg::elem_t                        data_o
);

    localparam int DEPTH   = `SA_DIM + SKEW;
    localparam int DEPTH_W = DEPTH * `SA_ELEM_W;

    // slot 0 drives the output, higher slots wait their turn
    systolic_pkg::elem_t [DEPTH-1:0] sreg_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sreg_q <= '0;
        end else if (load_i) begin
            // data lands above SKEW empty slots
            sreg_q <= DEPTH_W'(data_i) << (SKEW * `SA_ELEM_W);
        end else if (shift_i) begin
            sreg_q <= {`SA_ELEM_W'(0), sreg_q[DEPTH-1:1]};  // zeros fill in behind
        end
    end

    assign data_o = sreg_q[0];

endmodule

`default_nettype wire

// ==== hw/mac_pe.sv ====
// output-stationary multiply-accumulate cell that passes a to the right and b downward
`default_nettype none
`include "systolic_params.svh"

module mac_pe (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                clear_i,  // start of a new run
    input  wire logic                en_i,
    input  wire systolic_pkg::elem_t a_i,
    input  wire systolic_pkg::elem_t b_i,
    output systolic_pkg::elem_t      a_o,
    output systolic_pkg::elem_t      b_o,
    output systolic_pkg::acc_t       acc_o
);

    logic signed [2*`SA_ELEM_W-1:0] prod;  // exact int8 product
    systolic_pkg::acc_t             acc_q;
    systolic_pkg::elem_t            a_q;
    systolic_pkg::elem_t            b_q;

    assign prod = a_i * b_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q <= '0;
            a_q   <= '0;
            b_q   <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
            a_q   <= '0;
            b_q   <= '0;
        end else if (en_i) begin
            acc_q <= acc_q + prod;  // prod sign-extends to accumulator width
            a_q   <= a_i;
            b_q   <= b_i;
        end
    end

    // neighbours see this cycle's operands one cycle later
    assign a_o   = a_q;
    assign b_o   = b_q;
    assign acc_o = acc_q;

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
// 4x4 systolic grid with skewed edge feeders and the load, compute and done sequencer
`default_nettype none
`include "systolic_params.svh"

module systolic_array (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start_i,
    input  wire systolic_pkg::mm_operands_t ops_i,
    output logic                            busy_o,
    output logic                            done_o,
    output systolic_pkg::mm_result_t        result_o
);

    localparam int N     = `SA_DIM;
    localparam int CNT_W = $clog2(`SA_COMPUTE_CYCLES + 1);

    typedef enum logic [1:0] {IDLE, LOAD, COMPUTE, DONE} state_t;

    state_t           state_q;
    state_t           state_d;
    logic [CNT_W-1:0] cnt_q;  // compute cycles elapsed
    logic             load;
    logic             run;

    // a enters each row from the west, b enters each column from the north
    systolic_pkg::elem_t a_bus [N][N+1];
    systolic_pkg::elem_t b_bus [N+1][N];
    systolic_pkg::acc_t  acc   [N][N];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= (state_q == COMPUTE) ? cnt_q + 1'b1 : '0;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = LOAD;
            LOAD:    state_d = COMPUTE;  // clear cells and fill feeders
            COMPUTE: if (cnt_q == CNT_W'(`SA_COMPUTE_CYCLES - 1)) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    assign load   = (state_q == LOAD);
    assign run    = (state_q == COMPUTE);
    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);  // single cycle

    for (genvar i = 0; i < N; i++) begin : g_feed
        systolic_pkg::elem_t [N-1:0] b_col;

        always_comb begin
            for (int k = 0; k < N; k++) begin
                b_col[k] = ops_i.b[k][i];  // column i of b, top row first
            end
        end

        skew_feeder #(.SKEW(i)) u_feed_a (.clk(clk), .reset(reset), .load_i(load),
            .data_i(ops_i.a[i]), .shift_i(run), .data_o(a_bus[i][0]));

        skew_feeder #(.SKEW(i)) u_feed_b (.clk(clk), .reset(reset), .load_i(load),
            .data_i(b_col), .shift_i(run), .data_o(b_bus[0][i]));
    end

    // a[i][k] and b[k][j] meet in cell (i,j) in compute cycle k+i+j
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            mac_pe u_pe (.clk(clk), .reset(reset), .clear_i(load), .en_i(run),
                .a_i(a_bus[i][j]), .b_i(b_bus[i][j]),
                .a_o(a_bus[i][j+1]), .b_o(b_bus[i+1][j]), .acc_o(acc[i][j]));
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                result_o.c[i][j] = acc[i][j];
            end
        end
    end

    // the register block holds start back while a run is in flight
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start_i |-> !busy_o);

    // one load cycle and the full compute run separate start from done
    a_done_time: assert property (@(posedge clk) disable iff (reset)
        start_i |-> ##(`SA_COMPUTE_CYCLES + 2) done_o);

endmodule

`default_nettype wire

// ==== hw/mm_regs.sv ====
// axi4-lite register block holding the operands, start and status, and the result window
`default_nettype none
`include "systolic_params.svh"

module mm_regs (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire systolic_pkg::axil_req_t    axil_req_i,
    output systolic_pkg::axil_rsp_t         axil_rsp_o,
    output systolic_pkg::mm_operands_t      ops_o,
    output logic                            start_o,
    input  wire logic                       busy_i,
    input  wire logic                       done_i,  // one-cycle pulse from the array
    input  wire systolic_pkg::mm_result_t   result_i,
    output logic                            done_o
);

    localparam int         N           = `SA_DIM;
    localparam int         ROW_W       = $clog2(N);
    localparam int         IDX_W       = $clog2(N * N);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                       aw_held_q;
    logic [`SA_ADDR_W-1:0]      awaddr_q;
    logic                       w_held_q;
    logic [`SA_DATA_W-1:0]      wdata_q;
    logic                       bvalid_q;
    logic [1:0]                 bresp_q;
    logic                       rvalid_q;
    logic [`SA_DATA_W-1:0]      rdata_q;
    logic [1:0]                 rresp_q;
    systolic_pkg::mm_operands_t ops_q;
    logic                       done_q;  // sticky until the next start

    logic                       awready;
    logic                       wready;
    logic                       arready;
    logic                       wr_fire;
    logic                       wr_err;
    logic                       wr_ctrl;
    logic                       wr_a;
    logic                       wr_b;
    logic [ROW_W-1:0]           wr_row;
    logic                       rd_err;
    logic [`SA_DATA_W-1:0]      rd_data;
    logic [IDX_W-1:0]           rd_idx;

    function automatic logic in_block(input logic [`SA_ADDR_W-1:0] addr,
                                      input logic [`SA_ADDR_W-1:0] base, input int words);
        return (addr >= base) && (addr < base + `SA_ADDR_W'(4 * words));
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [`SA_ADDR_W-1:0] addr,
                                                    input logic [`SA_ADDR_W-1:0] base);
        logic [`SA_ADDR_W-1:0] off;
        off = addr - base;
        return off[IDX_W+1:2];
    endfunction

    // column 0 sits in the top byte
    function automatic logic [`SA_DATA_W-1:0] pack_row(input systolic_pkg::elem_t [N-1:0] row);
        logic [`SA_DATA_W-1:0] word;
        for (int j = 0; j < N; j++) begin
            word[(N-1-j)*`SA_ELEM_W +: `SA_ELEM_W] = row[j];
        end
        return word;
    endfunction

    function automatic systolic_pkg::elem_t [N-1:0] unpack_row(input logic [`SA_DATA_W-1:0] w);
        systolic_pkg::elem_t [N-1:0] row;
        for (int j = 0; j < N; j++) begin
            row[j] = w[(N-1-j)*`SA_ELEM_W +: `SA_ELEM_W];
        end
        return row;
    endfunction

    assign awready = !aw_held_q && !bvalid_q;  // nothing new while a response waits
    assign wready  = !w_held_q && !bvalid_q;
    assign arready = !rvalid_q;
    assign wr_fire = aw_held_q && w_held_q;   // write takes effect on the edge raising bvalid

    always_comb begin
        wr_err  = 1'b0;
        wr_ctrl = 1'b0;
        wr_a    = 1'b0;
        wr_b    = 1'b0;
        wr_row  = '0;
        if (awaddr_q[1:0] != 2'b00) begin
            wr_err = 1'b1;
        end else if (awaddr_q == `REG_CTRL) begin
            wr_ctrl = 1'b1;
        end else if (in_block(awaddr_q, `REG_A_BASE, N)) begin
            wr_a   = 1'b1;
            wr_row = ROW_W'(word_index(awaddr_q, `REG_A_BASE));
        end else if (in_block(awaddr_q, `REG_B_BASE, N)) begin
            wr_b   = 1'b1;
            wr_row = ROW_W'(word_index(awaddr_q, `REG_B_BASE));
        end else if (awaddr_q != `REG_STATUS) begin
            wr_err = 1'b1;  // results are read only and the rest is unmapped
        end
    end

    // a start during a run is acknowledged and dropped
    assign start_o = wr_fire && wr_ctrl && wdata_q[0] && !busy_i;

    always_comb begin
        rd_err  = 1'b0;
        rd_data = '0;
        rd_idx  = '0;
        if (axil_req_i.araddr[1:0] != 2'b00) begin
            rd_err = 1'b1;
        end else if (axil_req_i.araddr == `REG_STATUS) begin
            rd_data = {{(`SA_DATA_W-2){1'b0}}, done_q, busy_i};
        end else if (in_block(axil_req_i.araddr, `REG_A_BASE, N)) begin
            rd_idx  = word_index(axil_req_i.araddr, `REG_A_BASE);
            rd_data = pack_row(ops_q.a[rd_idx[ROW_W-1:0]]);
        end else if (in_block(axil_req_i.araddr, `REG_B_BASE, N)) begin
            rd_idx  = word_index(axil_req_i.araddr, `REG_B_BASE);
            rd_data = pack_row(ops_q.b[rd_idx[ROW_W-1:0]]);
        end else if (in_block(axil_req_i.araddr, `REG_C_BASE, N * N)) begin
            rd_idx  = word_index(axil_req_i.araddr, `REG_C_BASE);
            rd_data = result_i.c[rd_idx[IDX_W-1:ROW_W]][rd_idx[ROW_W-1:0]];
        end else if (axil_req_i.araddr != `REG_CTRL) begin
            rd_err = 1'b1;  // ctrl reads back as zero
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aw_held_q <= 1'b0;
            awaddr_q  <= '0;
            w_held_q  <= 1'b0;
            wdata_q   <= '0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            ops_q     <= '0;
            done_q    <= 1'b0;
        end else begin
            if (axil_req_i.awvalid && awready) begin
                aw_held_q <= 1'b1;
                awaddr_q  <= axil_req_i.awaddr;
            end
            if (axil_req_i.wvalid && wready) begin
                w_held_q <= 1'b1;
                wdata_q  <= axil_req_i.wdata;
            end
            if (wr_fire) begin
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
                bvalid_q  <= 1'b1;
                bresp_q   <= wr_err ? RESP_SLVERR : RESP_OKAY;
                if (wr_a) ops_q.a[wr_row] <= unpack_row(wdata_q);
                if (wr_b) ops_q.b[wr_row] <= unpack_row(wdata_q);
            end else if (bvalid_q && axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= RESP_OKAY;
        end else if (axil_req_i.arvalid && arready) begin
            rvalid_q <= 1'b1;
            rdata_q  <= rd_data;
            rresp_q  <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end else if (rvalid_q && axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready;
        axil_rsp_o.wready  = wready;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = arready;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

    assign ops_o  = ops_q;
    assign done_o = done_q;

    // responses stay put under back-pressure
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid && $stable(axil_rsp_o.bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp_o.rvalid && !axil_req_i.rready |=>
            axil_rsp_o.rvalid && $stable(axil_rsp_o.rdata) && $stable(axil_rsp_o.rresp));

endmodule

`default_nettype wire

// ==== hw/systolic_mm_top.sv ====
// top of the matrix multiplier with the axi4-lite register block steering the systolic array
`default_nettype none

module systolic_mm_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire systolic_pkg::axil_req_t axil_req_i,
    output systolic_pkg::axil_rsp_t      axil_rsp_o,
    output logic                         done_o  // mirrors the status done bit
);

    systolic_pkg::mm_operands_t ops;
    systolic_pkg::mm_result_t   result;
    logic                       start;
    logic                       busy;
    logic                       done_pulse;

    mm_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .ops_o      (ops),
        .start_o    (start),
        .busy_i     (busy),
        .done_i     (done_pulse),
        .result_i   (result),
        .done_o     (done_o)
    );

    systolic_array u_array (
        .clk      (clk),
        .reset    (reset),
        .start_i  (start),
        .ops_i    (ops),
        .busy_o   (busy),
        .done_o   (done_pulse),
        .result_o (result)
    );

endmodule

`default_nettype wire

// ==== dv/systolic_mm_tb.sv ====
// testbench for the systolic matrix multiplier, driving its axi4-lite port from the vectors file
`default_nettype none
`include "systolic_params.svh"

module systolic_mm_tb;

    localparam int         N          = `SA_DIM;
    localparam int         NUM_CASES  = 4;
    localparam int         CASE_WORDS = 2 * N + N * N;  // a rows, b rows, then c row-major
    localparam int         TIMEOUT    = 200;
    localparam int         DONE_DELAY = `SA_COMPUTE_CYCLES + 2;
    localparam logic [1:0] OKAY       = 2'b00;
    localparam logic [1:0] SLVERR     = 2'b10;

    logic                    clk;
    logic                    reset;
    systolic_pkg::axil_req_t req;
    systolic_pkg::axil_rsp_t rsp;
    logic                    done;

    logic [31:0] vec_mem [0:NUM_CASES*CASE_WORDS-1];
    integer      seed = 32'ha1ee;
    int          err_count = 0;
    int          check_count = 0;
    int          cycle_cnt = 0;
    int          resp_cycle = 0;  // cycle in which the last write took effect
    int          done_rise_cycle = 0;
    int          done_rises = 0;
    logic        done_seen = 1'b0;

    systolic_mm_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .axil_req_i (req),
        .axil_rsp_o (rsp),
        .done_o     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // done_o is steady at the falling edge
    always @(negedge clk) begin
        if (done && !done_seen) begin
            done_rise_cycle = cycle_cnt;
            done_rises      = done_rises + 1;
        end
        done_seen = done;
    end

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        err_count = err_count + 1;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        check_count = check_count + 1;
        assert (got === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, got);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_count = check_count + 1;
        assert (cond) else begin
            $display("error: %s", what);
            err_count = err_count + 1;
        end
    endtask

    function automatic int stall_cycles();
        return int'($unsigned($random(seed)) % 32'd4);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int         waited;
        logic       aw_go;
        logic       w_go;
        logic [1:0] held;
        waited      = 0;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        while (req.awvalid || req.wvalid) begin
            aw_go = req.awvalid && rsp.awready;  // readies only move at an edge
            w_go  = req.wvalid && rsp.wready;
            next_cycle();
            if (aw_go) req.awvalid = 1'b0;
            if (w_go) req.wvalid = 1'b0;
            waited = waited + 1;
            if (waited > TIMEOUT) timeout_abort("write address and data handshake");
        end
        waited = 0;
        while (!rsp.bvalid) begin
            next_cycle();
            waited = waited + 1;
            if (waited > TIMEOUT) timeout_abort("write response");
        end
        resp_cycle = cycle_cnt;
        held       = rsp.bresp;
        repeat (stall_cycles()) begin
            next_cycle();
            check_true(rsp.bvalid && rsp.bresp == held, "write response changed while stalled");
        end
        req.bready = 1'b1;
        resp       = rsp.bresp;
        next_cycle();
        req.bready = 1'b0;
        check_true(!rsp.bvalid, "write response repeated after its handshake");
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int          waited;
        logic        accepted;
        logic [31:0] held;
        waited      = 0;
        accepted    = 1'b0;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        while (!accepted) begin
            accepted = rsp.arready;  // taken at the coming edge
            next_cycle();
            waited = waited + 1;
            if (waited > TIMEOUT) timeout_abort("read address handshake");
        end
        req.arvalid = 1'b0;
        waited      = 0;
        while (!rsp.rvalid) begin
            next_cycle();
            waited = waited + 1;
            if (waited > TIMEOUT) timeout_abort("read data");
        end
        held = rsp.rdata;
        repeat (stall_cycles()) begin
            next_cycle();
            check_true(rsp.rvalid && rsp.rdata == held, "read data changed while stalled");
        end
        req.rready = 1'b1;
        data       = rsp.rdata;
        resp       = rsp.rresp;
        next_cycle();
        req.rready = 1'b0;
        check_true(!rsp.rvalid, "read data repeated after its handshake");
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value($sformatf("write response at %h", addr), 32'(OKAY), 32'(resp));
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value($sformatf("%s response", name), 32'(OKAY), 32'(resp));
        check_value(name, exp, data);
    endtask

    task automatic load_case(input int c);
        for (int i = 0; i < N; i++) begin
            write_ok(8'(`REG_A_BASE + 4 * i), vec_mem[c * CASE_WORDS + i]);
            write_ok(8'(`REG_B_BASE + 4 * i), vec_mem[c * CASE_WORDS + N + i]);
        end
    endtask

    task automatic check_results(input int c, input string label);
        for (int w = 0; w < N * N; w++) begin
            read_check(8'(`REG_C_BASE + 4 * w), vec_mem[c * CASE_WORDS + 2 * N + w],
                       $sformatf("%s c[%0d][%0d]", label, w / N, w % N));
        end
    endtask

    // polls status, then checks the pin and the start to done latency
    task automatic wait_done(input string label, input int start_cycle);
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[1]) begin
            axil_read(`REG_STATUS, status, resp);
            polls = polls + 1;
            if (polls > TIMEOUT) timeout_abort($sformatf("%s done bit", label));
        end
        check_value($sformatf("%s status", label), 32'h2, status);
        check_value($sformatf("%s done pin", label), 32'h1, 32'(done));
        check_value($sformatf("%s start to done cycles", label), 32'(DONE_DELAY),
                    32'(done_rise_cycle - start_cycle));
    endtask

    task automatic run_case(input int c);
        int    start_cycle;
        string label;
        label = $sformatf("case %0d", c);
        load_case(c);
        for (int i = 0; i < N; i++) begin
            read_check(8'(`REG_A_BASE + 4 * i), vec_mem[c * CASE_WORDS + i],
                       $sformatf("%s a row %0d", label, i));
            read_check(8'(`REG_B_BASE + 4 * i), vec_mem[c * CASE_WORDS + N + i],
                       $sformatf("%s b row %0d", label, i));
        end
        write_ok(`REG_CTRL, 32'h1);
        start_cycle = resp_cycle;
        wait_done(label, start_cycle);
        check_results(c, label);
    endtask

    task automatic check_reset_state();
        check_value("done pin after reset", 32'h0, 32'(done));
        read_check(`REG_STATUS, 32'h0, "status after reset");
        for (int w = 0; w < N * N; w++) begin
            read_check(8'(`REG_C_BASE + 4 * w), 32'h0, $sformatf("c word %0d after reset", w));
        end
    endtask

    // second start and an operand rewrite land while the first run is in flight
    task automatic check_busy_start();
        int start_cycle;
        int rises;
        load_case(2);
        write_ok(`REG_CTRL, 32'h1);
        start_cycle = resp_cycle;
        rises       = done_rises;
        write_ok(`REG_CTRL, 32'h1);
        write_ok(`REG_A_BASE, 32'h1122_3344);
        wait_done("busy start", start_cycle);
        check_results(2, "busy start");
        check_value("busy start done count", 32'h1, 32'(done_rises - rises));
    endtask

    // the c registers still hold the case 2 results of the busy start run
    task automatic check_error_responses();
        logic [31:0] data;
        logic [31:0] held_c;
        logic [1:0]  resp;
        held_c = vec_mem[2 * CASE_WORDS + 2 * N + 1];  // c[0][1] of case 2
        axil_read(8'h08, data, resp);
        check_value("unmapped read response", 32'(SLVERR), 32'(resp));
        axil_write(8'h80, 32'h1234_5678, resp);
        check_value("unmapped write response", 32'(SLVERR), 32'(resp));
        read_check(8'(`REG_C_BASE + 4), held_c, "c register before write");
        axil_write(8'(`REG_C_BASE + 4), ~held_c, resp);
        check_value("c register write response", 32'(SLVERR), 32'(resp));
        read_check(8'(`REG_C_BASE + 4), held_c, "c register after write");
    endtask

    initial begin
        req   = '0;
        reset = 1'b1;
        $readmemh("dv/systolic_mm_vectors.txt", vec_mem);
        repeat (5) next_cycle();
        reset = 1'b0;
        next_cycle();
        check_reset_state();
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        check_busy_start();
        check_error_responses();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== systolic_mm.f ====
+incdir+include
hw/systolic_pkg.sv
hw/skew_feeder.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/mm_regs.sv
hw/systolic_mm_top.sv
dv/systolic_mm_tb.sv

// ==== Makefile ====
# Verilator build and run of the systolic matrix multiplier testbench

VERILATOR ?= verilator
TOP       ?= systolic_mm_tb
FILELIST  ?= systolic_mm.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(VERILATOR), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/systolic_mm_vectors.txt ====
// per case: a rows 0..3 on one line, b rows 0..3 on the next, then c as four lines row-major
// a and b words hold columns 0..3 from the top byte down, c words are signed 32-bit
// case 0: identity times mixed-sign b
01000000 00010000 00000100 00000001
01020304 FFFEFDFC 7F8010F0 0005FB40
00000001 00000002 00000003 00000004
FFFFFFFF FFFFFFFE FFFFFFFD FFFFFFFC
0000007F FFFFFF80 00000010 FFFFFFF0
00000000 00000005 FFFFFFFB 00000040
// case 1: -128 times -128 everywhere
80808080 80808080 80808080 80808080
80808080 80808080 80808080 80808080
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
00010000 00010000 00010000 00010000
// case 2: general signed product
01020304 FF0002FD 05FA07F8 0A14E228
02FF0003 01010101 FE04FD00 00FB0607
FFFFFFFE FFFFFFF9 00000011 00000021
FFFFFFFA 00000018 FFFFFFE8 FFFFFFE8
FFFFFFF6 00000039 FFFFFFB5 FFFFFFD1
00000064 FFFFFECA 0000015E 0000014A
// case 3: extreme values and a zero row
7F7F7F7F 80808080 7F807F80 00000000
7F8001FF 7F8001FF 7F8001FF 7F8001FF
0000FC04 FFFF0200 000001FC FFFFFE04
FFFF0200 00010000 FFFFFE00 00000200
FFFFFF02 00000100 FFFFFFFE 00000002
00000000 00000000 00000000 00000000
